/* include/cd_dma_macros.svh */
// Register offsets are {page hit, CPU address bits 8:1}. The page bit is set by
// the bus decoder for writes inside the FF0000-FF01FF register window.
`ifndef CD_DMA_MACROS_SVH
`define CD_DMA_MACROS_SVH

// ==========================================================================
// Register offsets
// ==========================================================================
`define CD_OFS_ADDR_A_HI    9'h132  // FF0064
`define CD_OFS_ADDR_A_LO    9'h133  // FF0066
`define CD_OFS_ADDR_B_HI    9'h134  // FF0068
`define CD_OFS_ADDR_B_LO    9'h135  // FF006A
`define CD_OFS_VALUE        9'h136  // FF006C, upper value word
`define CD_OFS_COUNT_HI     9'h138  // FF0070
`define CD_OFS_COUNT_LO     9'h139  // FF0072
`define CD_OFS_MICROCODE    9'h13F  // FF007E, first microcode word
`define CD_OFS_START        9'h130  // FF0061, low byte
`define CD_OFS_AREA         9'h182  // FF0105
`define CD_OFS_MAP_SPR      9'h190
`define CD_OFS_MAP_PCM      9'h191
`define CD_OFS_MAP_Z80      9'h193
`define CD_OFS_MAP_FIX      9'h194
`define CD_OFS_UNMAP_SPR    9'h1A0
`define CD_OFS_UNMAP_PCM    9'h1A1
`define CD_OFS_UNMAP_Z80    9'h1A3
`define CD_OFS_UNMAP_FIX    9'h1A4

`define CD_START_BIT        6

// Two microcode variants per operation
`define CD_UC_COPY_WORD_A   16'hFE6D
`define CD_UC_COPY_WORD_B   16'hFE3D
`define CD_UC_COPY_BYTE_A   16'hF2DD
`define CD_UC_COPY_BYTE_B   16'hE2DD
`define CD_UC_FILL_A        16'hFFCD
`define CD_UC_FILL_B        16'hFFDD

`define CD_UPLOAD_ZONE      4'hE    // Address bits 23:20
`define CD_AREA_SPR         3'd0
`define CD_AREA_PCM         3'd1
`define CD_AREA_Z80         3'd4
`define CD_AREA_FIX         3'd5

`endif

/* src/cd_dma_pkg.sv */
// Shared types of the DMA block. Addresses are byte addresses, counts are in
// words. region_t serves for both the use map and the write strobes.
package cd_dma_pkg;

	typedef logic [23:0] addr_t;
	typedef logic [15:0] word_t;
	typedef logic [23:0] count_t;   // Enough for any real transfer
	typedef logic [8:0]  reg_ofs_t; // {page hit, word offset}

	typedef enum logic [1:0]
	{
		MODE_COPY_WORD,
		MODE_COPY_BYTE,
		MODE_FILL
	} dma_mode_t;

	typedef enum logic [3:0]
	{
		IDLE,
		BUS_REQ,
		WAIT_GRANT,
		WAIT_QUIET,
		RUN,
		RD_REQ,
		RD_WAIT,
		WR_REQ,
		NEXT
	} dma_state_t;

	typedef struct packed
	{
		reg_ofs_t    ofs;
		word_t       data;
		logic [1:0]  be;   // Bit 1 is the upper byte
	} cpu_wr_t;

	typedef struct packed
	{
		dma_mode_t   mode;
		addr_t       addr_a;
		addr_t       addr_b;
		word_t       value;
		count_t      count;
	} dma_cfg_t;

	typedef struct packed
	{
		logic        write;
		addr_t       addr;
		word_t       data;
	} mem_req_t;

	typedef struct packed
	{
		logic        spr;
		logic        pcm;
		logic        z80;
		logic        fix;
	} region_t;

endpackage

/* src/cd_dma_regs.sv */
// CPU register writes are always accepted, one per valid cycle. Address, value
// and count halves need a full-word write. Only microcode word 0 is decoded,
// and a start with an unknown microcode is dropped.
`timescale 1ns/1ps
`include "cd_dma_macros.svh"

module cd_dma_regs
(
	input  logic                  clk_sys,
	input  logic                  nRESET,
	input  cd_dma_pkg::cpu_wr_t   cpu_wr,
	input  logic                  cpu_wr_valid,
	output cd_dma_pkg::dma_cfg_t  dma_cfg,
	output logic                  dma_start,
	output logic [2:0]            tr_area,
	output cd_dma_pkg::region_t   use_map
);

	cd_dma_pkg::word_t      microcode;
	cd_dma_pkg::dma_mode_t  uc_mode;
	logic                   uc_known;
	logic                   wr_word;
	logic                   wr_low;
	logic                   start_hit;

	assign wr_word = cpu_wr_valid & (cpu_wr.be == 2'b11);
	assign wr_low  = cpu_wr_valid & cpu_wr.be[0];

	assign start_hit = wr_low & (cpu_wr.ofs == `CD_OFS_START) &
		cpu_wr.data[`CD_START_BIT];

	// Microcode word 0 selects the operation
	always_comb
	begin
		uc_known = 1'b1;
		case (microcode)
			`CD_UC_COPY_WORD_A, `CD_UC_COPY_WORD_B: uc_mode = cd_dma_pkg::MODE_COPY_WORD;
			`CD_UC_COPY_BYTE_A, `CD_UC_COPY_BYTE_B: uc_mode = cd_dma_pkg::MODE_COPY_BYTE;
			`CD_UC_FILL_A, `CD_UC_FILL_B:           uc_mode = cd_dma_pkg::MODE_FILL;
			default:
			begin
				uc_mode  = cd_dma_pkg::MODE_COPY_WORD;
				uc_known = 1'b0;
			end
		endcase
	end

	// ==========================================================================
	// Transfer configuration
	// ==========================================================================
	always_ff @(posedge clk_sys)
	begin
		if (wr_word)
		begin
			case (cpu_wr.ofs)
				`CD_OFS_ADDR_A_HI: dma_cfg.addr_a[23:16] <= cpu_wr.data[7:0];
				`CD_OFS_ADDR_A_LO: dma_cfg.addr_a[15:0]  <= cpu_wr.data;
				`CD_OFS_ADDR_B_HI: dma_cfg.addr_b[23:16] <= cpu_wr.data[7:0];
				`CD_OFS_ADDR_B_LO: dma_cfg.addr_b[15:0]  <= cpu_wr.data;
				`CD_OFS_VALUE:     dma_cfg.value         <= cpu_wr.data;
				`CD_OFS_COUNT_HI:  dma_cfg.count[23:16]  <= cpu_wr.data[7:0];
				`CD_OFS_COUNT_LO:  dma_cfg.count[15:0]   <= cpu_wr.data;
				`CD_OFS_MICROCODE: microcode             <= cpu_wr.data;
				default: ;
			endcase
		end

		if (start_hit && uc_known)
			dma_cfg.mode <= uc_mode;   // Valid together with dma_start
	end

	// ==========================================================================
	// Start strobe, area select and upload map
	// ==========================================================================
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			dma_start <= 1'b0;
			tr_area   <= 3'd0;
			use_map   <= '0;
		end
		else
		begin
			dma_start <= start_hit & uc_known;   // One cycle only

			if (wr_low)
			begin
				case (cpu_wr.ofs)
					`CD_OFS_AREA:      tr_area     <= cpu_wr.data[2:0];
					`CD_OFS_MAP_SPR:   use_map.spr <= 1'b1;
					`CD_OFS_MAP_PCM:   use_map.pcm <= 1'b1;
					`CD_OFS_MAP_Z80:   use_map.z80 <= 1'b1;
					`CD_OFS_MAP_FIX:   use_map.fix <= 1'b1;
					`CD_OFS_UNMAP_SPR: use_map.spr <= 1'b0;
					`CD_OFS_UNMAP_PCM: use_map.pcm <= 1'b0;
					`CD_OFS_UNMAP_Z80: use_map.z80 <= 1'b0;
					`CD_OFS_UNMAP_FIX: use_map.fix <= 1'b0;
					default: ;
				endcase
			end
		end
	end

endmodule

/* src/cd_dma_engine.sv */
// Starts are only taken in IDLE. Addresses step by 2 after each access and are
// not checked for alignment. At most one read is in flight, and a read waits
// for its response with no limit.
`timescale 1ns/1ps

module cd_dma_engine
(
	input  logic                  clk_sys,
	input  logic                  nRESET,
	input  cd_dma_pkg::dma_cfg_t  dma_cfg,
	input  logic                  dma_start,
	input  logic                  bus_grant,
	input  logic                  bus_quiet,
	input  logic                  mem_req_ready,
	input  logic                  mem_rd_valid,
	input  cd_dma_pkg::word_t     mem_rd_data,
	output logic                  bus_req,
	output logic                  bus_ack,
	output logic                  dma_running,
	output cd_dma_pkg::mem_req_t  mem_req,
	output logic                  mem_req_valid
);

	cd_dma_pkg::dma_state_t  state;
	cd_dma_pkg::dma_mode_t   mode;
	cd_dma_pkg::addr_t       rd_addr;
	cd_dma_pkg::addr_t       wr_addr;
	cd_dma_pkg::word_t       value;
	cd_dma_pkg::word_t       rd_data;
	cd_dma_pkg::word_t       wr_data;
	cd_dma_pkg::count_t      count_run;
	logic [1:0]              io_cnt;      // Access step within one unit
	logic                    act_rd;
	logic                    act_wr;

	// Next access of the current unit, in RUN
	always_comb
	begin
		act_rd = 1'b0;
		act_wr = 1'b0;
		case (mode)
			cd_dma_pkg::MODE_COPY_WORD:
			begin
				act_rd = (io_cnt == 2'd0);
				act_wr = (io_cnt == 2'd1);
			end
			cd_dma_pkg::MODE_COPY_BYTE:
			begin
				act_rd = (io_cnt == 2'd0);
				act_wr = (io_cnt == 2'd1) || (io_cnt == 2'd2);   // Swapped, then original
			end
			cd_dma_pkg::MODE_FILL:  act_wr = (io_cnt == 2'd0);
			default: ;
		endcase
	end

	always_comb
	begin
		if (mode == cd_dma_pkg::MODE_FILL)
			wr_data = value;
		else if (mode == cd_dma_pkg::MODE_COPY_BYTE && io_cnt == 2'd1)
			wr_data = {rd_data[7:0], rd_data[15:8]};
		else
			wr_data = rd_data;
	end

	// Request is a decode of the state, so it holds until accepted
	assign mem_req_valid = (state == cd_dma_pkg::RD_REQ) || (state == cd_dma_pkg::WR_REQ);
	assign mem_req.write = (state == cd_dma_pkg::WR_REQ);
	assign mem_req.addr  = mem_req.write ? wr_addr : rd_addr;
	assign mem_req.data  = wr_data;

	// ==========================================================================
	// Control FSM and bus handshake
	// ==========================================================================
	always_ff @(posedge clk_sys or negedge nRESET)
	begin
		if (!nRESET)
		begin
			state       <= cd_dma_pkg::IDLE;
			io_cnt      <= 2'd0;
			bus_req     <= 1'b0;
			bus_ack     <= 1'b0;
			dma_running <= 1'b0;
		end
		else
		begin
			case (state)
				cd_dma_pkg::IDLE:
				begin
					io_cnt <= 2'd0;
					if (dma_start)
						state <= cd_dma_pkg::BUS_REQ;
				end
				cd_dma_pkg::BUS_REQ:
				begin
					bus_req <= 1'b1;
					state   <= cd_dma_pkg::WAIT_GRANT;
				end
				cd_dma_pkg::WAIT_GRANT:
				begin
					if (bus_grant)
					begin
						bus_req <= 1'b0;
						state   <= cd_dma_pkg::WAIT_QUIET;
					end
				end
				cd_dma_pkg::WAIT_QUIET:
				begin
					if (bus_quiet)   // CPU strobes idle, take the bus
					begin
						bus_ack     <= 1'b1;
						dma_running <= 1'b1;
						state       <= cd_dma_pkg::RUN;
					end
				end
				cd_dma_pkg::RUN:
				begin
					if (count_run == '0)
					begin
						bus_ack     <= 1'b0;
						dma_running <= 1'b0;
						state       <= cd_dma_pkg::IDLE;
					end
					else if (act_rd)
						state <= cd_dma_pkg::RD_REQ;
					else if (act_wr)
						state <= cd_dma_pkg::WR_REQ;
					else
						state <= cd_dma_pkg::NEXT;
				end
				cd_dma_pkg::RD_REQ:
				begin
					if (mem_req_ready)
						state <= cd_dma_pkg::RD_WAIT;
				end
				cd_dma_pkg::RD_WAIT:
				begin
					if (mem_rd_valid)
					begin
						io_cnt <= io_cnt + 2'd1;
						state  <= cd_dma_pkg::RUN;
					end
				end
				cd_dma_pkg::WR_REQ:
				begin
					if (mem_req_ready)
					begin
						io_cnt <= io_cnt + 2'd1;
						state  <= cd_dma_pkg::RUN;
					end
				end
				cd_dma_pkg::NEXT:
				begin
					io_cnt <= 2'd0;
					state  <= cd_dma_pkg::RUN;
				end
				default: state <= cd_dma_pkg::IDLE;
			endcase
		end
	end

	// ==========================================================================
	// Datapath
	// ==========================================================================
	always_ff @(posedge clk_sys)
	begin
		case (state)
			cd_dma_pkg::IDLE:
			begin
				if (dma_start)
				begin
					mode      <= dma_cfg.mode;
					value     <= dma_cfg.value;
					count_run <= dma_cfg.count;
					rd_addr   <= dma_cfg.addr_a;
					// Fill writes from A, copies write to B
					wr_addr   <= (dma_cfg.mode == cd_dma_pkg::MODE_FILL) ?
						dma_cfg.addr_a : dma_cfg.addr_b;
				end
			end
			cd_dma_pkg::RD_REQ:  if (mem_req_ready) rd_addr <= rd_addr + 24'd2;
			cd_dma_pkg::RD_WAIT: if (mem_rd_valid) rd_data <= mem_rd_data;
			cd_dma_pkg::WR_REQ:  if (mem_req_ready) wr_addr <= wr_addr + 24'd2;
			cd_dma_pkg::NEXT:    count_run <= count_run - 24'd1;
			default: ;
		endcase
	end

endmodule

/* src/cd_upload_gate.sv */
// Purely combinational. Only DMA writes are gated here, reads from the upload
// zone raise no strobe. Area codes outside the four listed raise nothing.
`timescale 1ns/1ps
`include "cd_dma_macros.svh"

module cd_upload_gate
(
	input  cd_dma_pkg::mem_req_t  mem_req,
	input  logic                  mem_req_valid,
	input  logic                  mem_req_ready,
	input  logic [2:0]            tr_area,
	input  cd_dma_pkg::region_t   use_map,
	output cd_dma_pkg::region_t   tr_wr
);

	logic zone_wr;
	cd_dma_pkg::region_t area_sel;

	// Write accepted this cycle inside the E zone
	assign zone_wr = mem_req_valid & mem_req_ready & mem_req.write &
		(mem_req.addr[23:20] == `CD_UPLOAD_ZONE);

	assign area_sel.spr = (tr_area == `CD_AREA_SPR);
	assign area_sel.pcm = (tr_area == `CD_AREA_PCM);
	assign area_sel.z80 = (tr_area == `CD_AREA_Z80);
	assign area_sel.fix = (tr_area == `CD_AREA_FIX);

	// Region must also be mapped
	assign tr_wr = zone_wr ? (area_sel & use_map) : '0;

endmodule

/* src/cd_dma_top.sv */
// DMA part of the CD system controller. CPU register writes are fire and
// forget. The memory port uses valid/ready, with read data on mem_rd_valid.
`timescale 1ns/1ps

module cd_dma_top
(
	input  logic                  clk_sys,
	input  logic                  nRESET,
	input  cd_dma_pkg::cpu_wr_t   cpu_wr,
	input  logic                  cpu_wr_valid,
	output logic                  bus_req,
	input  logic                  bus_grant,
	input  logic                  bus_quiet,
	output logic                  bus_ack,
	output logic                  dma_running,
	output cd_dma_pkg::mem_req_t  mem_req,
	output logic                  mem_req_valid,
	input  logic                  mem_req_ready,
	input  logic                  mem_rd_valid,
	input  cd_dma_pkg::word_t     mem_rd_data,
	output cd_dma_pkg::region_t   tr_wr
);

	cd_dma_pkg::dma_cfg_t  dma_cfg;
	cd_dma_pkg::region_t   use_map;
	logic                  dma_start;
	logic [2:0]            tr_area;

	cd_dma_regs u_regs
	(
		.clk_sys(clk_sys), .nRESET(nRESET),
		.cpu_wr(cpu_wr), .cpu_wr_valid(cpu_wr_valid),
		.dma_cfg(dma_cfg), .dma_start(dma_start),
		.tr_area(tr_area), .use_map(use_map)
	);

	cd_dma_engine u_engine
	(
		.clk_sys(clk_sys), .nRESET(nRESET),
		.dma_cfg(dma_cfg), .dma_start(dma_start),
		.bus_grant(bus_grant), .bus_quiet(bus_quiet),
		.mem_req_ready(mem_req_ready),
		.mem_rd_valid(mem_rd_valid), .mem_rd_data(mem_rd_data),
		.bus_req(bus_req), .bus_ack(bus_ack), .dma_running(dma_running),
		.mem_req(mem_req), .mem_req_valid(mem_req_valid)
	);

	cd_upload_gate u_gate
	(
		.mem_req(mem_req), .mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready),
		.tr_area(tr_area), .use_map(use_map),
		.tr_wr(tr_wr)
	);

endmodule

/* sim/cd_dma_checker.sv */
// Watches the CPU write port and the memory port of the DMA block. It predicts
// every DMA memory write in order and the region strobe that goes with it.
// Inputs are sampled on the falling clock edge, where they are stable.
`timescale 1ns/1ps
`include "cd_dma_macros.svh"

module cd_dma_checker
(
	input  logic                  clk_sys,
	input  logic                  nRESET,
	input  cd_dma_pkg::cpu_wr_t   cpu_wr,
	input  logic                  cpu_wr_valid,
	input  logic                  bus_req,
	input  logic                  bus_grant,
	input  logic                  bus_quiet,
	input  logic                  bus_ack,
	input  logic                  dma_running,
	input  cd_dma_pkg::mem_req_t  mem_req,
	input  logic                  mem_req_valid,
	input  logic                  mem_req_ready,
	input  cd_dma_pkg::region_t   tr_wr
);

	cd_dma_pkg::word_t     model_mem [cd_dma_pkg::addr_t];
	cd_dma_pkg::addr_t     m_a;
	cd_dma_pkg::addr_t     m_b;
	cd_dma_pkg::word_t     m_value;
	cd_dma_pkg::word_t     m_uc;
	cd_dma_pkg::count_t    m_count;
	logic [2:0]            m_area;
	cd_dma_pkg::region_t   m_map;
	cd_dma_pkg::mem_req_t  exp_q [$];
	logic                  busy = 1'b0;
	logic                  seen_grant = 1'b0;
	logic                  seen_quiet = 1'b0;
	logic                  prev_running = 1'b0;
	string                 test_name = "reset";
	int                    test_errs = 0;
	int                    fail_count = 0;
	int                    tests_run = 0;
	int                    tests_failed = 0;

	// Unwritten memory reads back a pattern of the whole address
	function automatic cd_dma_pkg::word_t mem_word(input cd_dma_pkg::addr_t a);
		if (model_mem.exists(a))
			return model_mem[a];
		return a[15:0] ^ {a[7:0], a[23:16]};
	endfunction

	// 0 word copy, 1 byte copy, 2 fill, -1 not recognised
	function automatic int uc_mode(input cd_dma_pkg::word_t uc);
		case (uc)
			`CD_UC_COPY_WORD_A, `CD_UC_COPY_WORD_B: return 0;
			`CD_UC_COPY_BYTE_A, `CD_UC_COPY_BYTE_B: return 1;
			`CD_UC_FILL_A, `CD_UC_FILL_B:           return 2;
			default:                                return -1;
		endcase
	endfunction

	task automatic push_write(input cd_dma_pkg::addr_t a, input cd_dma_pkg::word_t d);
		exp_q.push_back('{1'b1, a, d});
		model_mem[a] = d;   // Later reads of the same run see it
	endtask

	task automatic predict(input int mode);
		cd_dma_pkg::addr_t ra;
		cd_dma_pkg::addr_t wa;
		cd_dma_pkg::word_t w;
		ra = m_a;
		wa = (mode == 2) ? m_a : m_b;
		for (int i = 0; i < m_count; i++)
		begin
			w  = mem_word(ra);
			ra = ra + 24'd2;
			if (mode == 2)
				push_write(wa, m_value);
			else if (mode == 1)
			begin
				push_write(wa, {w[7:0], w[15:8]});
				wa = wa + 24'd2;
				push_write(wa, w);
			end
			else
				push_write(wa, w);
			wa = wa + 24'd2;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("FAIL %s: %s", test_name, msg);
		test_errs++;
		fail_count++;
	endtask

	task automatic value_mismatch(input string what, input logic [23:0] exp, input logic [23:0] act);
		$display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
		test_errs++;
		fail_count++;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errs == 0)
			$display("PASS %s", name);
		else
		begin
			tests_failed++;
			$display("FAIL %s with %0d errors", name, test_errs);
		end
	endtask

	task automatic report_totals();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, fail_count);
	endtask

	// ==========================================================================
	// Register model and per-cycle comparison
	// ==========================================================================
	always @(negedge clk_sys)
	begin : watch
		cd_dma_pkg::mem_req_t e;
		cd_dma_pkg::region_t  exp_tr;
		logic                 xfer;
		if (!nRESET)
		begin
			m_area = 3'd0;
			m_map  = '0;
			busy   = 1'b0;
			prev_running = 1'b0;
			exp_q.delete();
		end
		else
		begin
			if (cpu_wr_valid && cpu_wr.be == 2'b11)
			begin
				case (cpu_wr.ofs)
					`CD_OFS_ADDR_A_HI: m_a[23:16]     = cpu_wr.data[7:0];
					`CD_OFS_ADDR_A_LO: m_a[15:0]      = cpu_wr.data;
					`CD_OFS_ADDR_B_HI: m_b[23:16]     = cpu_wr.data[7:0];
					`CD_OFS_ADDR_B_LO: m_b[15:0]      = cpu_wr.data;
					`CD_OFS_VALUE:     m_value        = cpu_wr.data;
					`CD_OFS_COUNT_HI:  m_count[23:16] = cpu_wr.data[7:0];
					`CD_OFS_COUNT_LO:  m_count[15:0]  = cpu_wr.data;
					`CD_OFS_MICROCODE: m_uc           = cpu_wr.data;
					default: ;
				endcase
			end
			if (cpu_wr_valid && cpu_wr.be[0])
			begin
				case (cpu_wr.ofs)
					`CD_OFS_AREA:      m_area    = cpu_wr.data[2:0];
					`CD_OFS_MAP_SPR:   m_map.spr = 1'b1;
					`CD_OFS_MAP_PCM:   m_map.pcm = 1'b1;
					`CD_OFS_MAP_Z80:   m_map.z80 = 1'b1;
					`CD_OFS_MAP_FIX:   m_map.fix = 1'b1;
					`CD_OFS_UNMAP_SPR: m_map.spr = 1'b0;
					`CD_OFS_UNMAP_PCM: m_map.pcm = 1'b0;
					`CD_OFS_UNMAP_Z80: m_map.z80 = 1'b0;
					`CD_OFS_UNMAP_FIX: m_map.fix = 1'b0;
					`CD_OFS_START:
					begin
						// A start while busy is dropped
						if (cpu_wr.data[`CD_START_BIT] && uc_mode(m_uc) >= 0 && !busy)
						begin
							busy       = 1'b1;
							seen_grant = 1'b0;
							seen_quiet = 1'b0;
							predict(uc_mode(m_uc));
						end
					end
					default: ;
				endcase
			end

			if (busy && seen_grant && bus_quiet)
				seen_quiet = 1'b1;
			if (busy && bus_grant)
				seen_grant = 1'b1;

			// No bus activity unless a start was taken
			if (!busy && (bus_req !== 1'b0 || dma_running !== 1'b0))
				note_failure("bus requested or DMA running without an accepted start");

			xfer = mem_req_valid & mem_req_ready;
			if (xfer && !(seen_quiet && bus_ack && dma_running))
				note_failure("memory request without bus grant, quiet bus, ack and running");
			if (xfer && mem_req.write)
			begin
				if (exp_q.size() == 0)
					note_failure("unexpected memory write");
				else
				begin
					e = exp_q.pop_front();
					if (mem_req.addr !== e.addr)
						value_mismatch("write address", e.addr, mem_req.addr);
					if (mem_req.data !== e.data)
						value_mismatch("write data", {8'h0, e.data}, {8'h0, mem_req.data});
				end
			end

			// Strobe only for a transferred write inside the upload zone
			exp_tr = '0;
			if (xfer && mem_req.write && mem_req.addr[23:20] == `CD_UPLOAD_ZONE)
			begin
				case (m_area)
					`CD_AREA_SPR: exp_tr.spr = m_map.spr;
					`CD_AREA_PCM: exp_tr.pcm = m_map.pcm;
					`CD_AREA_Z80: exp_tr.z80 = m_map.z80;
					`CD_AREA_FIX: exp_tr.fix = m_map.fix;
					default: ;
				endcase
			end
			if (tr_wr !== exp_tr)
				value_mismatch("tr_wr", {20'h0, exp_tr}, {20'h0, tr_wr});

			if (prev_running && !dma_running)
			begin
				busy = 1'b0;
				if (exp_q.size() != 0)
					note_failure($sformatf("dma_running fell with %0d writes missing", exp_q.size()));
				exp_q.delete();
			end
			prev_running = dma_running;
		end
	end

endmodule

/* sim/tb_cd_dma.sv */
// Random DMA runs from a Galois LFSR seeded with 46. The bus model grants
// after a random delay, the memory model stalls ready and delays read data.
// Every wait is bounded, so a stuck DUT shows up as a reported failure.
`timescale 1ns/1ps
`include "cd_dma_macros.svh"

module tb_cd_dma;

	logic                  clk_sys = 1'b0;
	logic                  nRESET;
	cd_dma_pkg::cpu_wr_t   cpu_wr;
	logic                  cpu_wr_valid;
	logic                  bus_req;
	logic                  bus_grant;
	logic                  bus_quiet;
	logic                  bus_ack;
	logic                  dma_running;
	cd_dma_pkg::mem_req_t  mem_req;
	logic                  mem_req_valid;
	logic                  mem_req_ready;
	logic                  mem_rd_valid;
	cd_dma_pkg::word_t     mem_rd_data;
	cd_dma_pkg::region_t   tr_wr;

	logic [15:0]           lfsr = 16'd46;
	cd_dma_pkg::word_t     mem [cd_dma_pkg::addr_t];
	logic                  xfer = 1'b0;
	cd_dma_pkg::mem_req_t  xfer_req;
	cd_dma_pkg::addr_t     rd_addr;
	logic                  rd_pend = 1'b0;
	int                    rd_delay = 0;
	int                    grant_delay = 0;

	cd_dma_top DUT
	(
		.clk_sys(clk_sys), .nRESET(nRESET),
		.cpu_wr(cpu_wr), .cpu_wr_valid(cpu_wr_valid),
		.bus_req(bus_req), .bus_grant(bus_grant), .bus_quiet(bus_quiet),
		.bus_ack(bus_ack), .dma_running(dma_running),
		.mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_rd_valid(mem_rd_valid), .mem_rd_data(mem_rd_data), .tr_wr(tr_wr)
	);

	cd_dma_checker chk
	(
		.clk_sys(clk_sys), .nRESET(nRESET),
		.cpu_wr(cpu_wr), .cpu_wr_valid(cpu_wr_valid),
		.bus_req(bus_req), .bus_grant(bus_grant), .bus_quiet(bus_quiet), .bus_ack(bus_ack),
		.dma_running(dma_running), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
		.mem_req_ready(mem_req_ready), .tr_wr(tr_wr)
	);

	always #2 clk_sys = ~clk_sys;

	// One LFSR step per bit taken
	function automatic logic [23:0] rnd(input int n);
		logic [23:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r    = {r[22:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	// Even address, in the upload zone about half of the time
	function automatic cd_dma_pkg::addr_t pick_address();
		logic [23:0]       r;
		cd_dma_pkg::addr_t a;
		r = rnd(19);
		a = {4'h0, r[18:0], 1'b0};
		r = rnd(1);
		if (r[0])
			a[23:20] = `CD_UPLOAD_ZONE;
		else
		begin
			r        = rnd(4);
			a[23:20] = r[3:0];
		end
		return a;
	endfunction

	// ==========================================================================
	// Bus and memory models
	// ==========================================================================
	always @(negedge clk_sys)
	begin
		xfer     = mem_req_valid & mem_req_ready;
		xfer_req = mem_req;
	end

	always @(posedge clk_sys)
	begin
		#1;
		if (nRESET)
		begin
			bus_quiet    = (rnd(2) != 0);
			mem_rd_valid = 1'b0;
			if (!bus_req)
			begin
				bus_grant   = 1'b0;
				grant_delay = rnd(3);
			end
			else if (grant_delay > 0)
				grant_delay--;
			else
				bus_grant = 1'b1;

			if (xfer && xfer_req.write)
				mem[xfer_req.addr] = xfer_req.data;
			else if (xfer)
			begin
				rd_pend  = 1'b1;
				rd_addr  = xfer_req.addr;
				rd_delay = rnd(2);
			end
			else if (rd_pend && rd_delay == 0)
			begin
				mem_rd_valid = 1'b1;
				mem_rd_data  = mem.exists(rd_addr) ? mem[rd_addr] :
					(rd_addr[15:0] ^ {rd_addr[7:0], rd_addr[23:16]});
				rd_pend = 1'b0;
			end
			else if (rd_pend)
				rd_delay--;
			mem_req_ready = (rnd(2) != 0);   // Ready low a quarter of the time
		end
	end

	task automatic write_reg(input cd_dma_pkg::reg_ofs_t ofs, input cd_dma_pkg::word_t data,
		input logic [1:0] be);
		@(posedge clk_sys);
		#1;
		cpu_wr       = '{ofs, data, be};
		cpu_wr_valid = 1'b1;
		@(posedge clk_sys);
		#1;
		cpu_wr_valid = 1'b0;
	endtask

	task automatic wait_running(input logic level, input int limit);
		int n;
		n = 0;
		while (dma_running !== level && n < limit)
		begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (dma_running !== level)
			chk.note_failure($sformatf("timeout waiting for dma_running to be %0d", level));
	endtask

	task automatic set_region(input cd_dma_pkg::reg_ofs_t map_ofs,
		input cd_dma_pkg::reg_ofs_t unmap_ofs);
		write_reg(rnd(1) ? map_ofs : unmap_ofs, 16'h0000, 2'b01);
	endtask

	task automatic run_dma(input string name, input cd_dma_pkg::word_t uc, input logic restart);
		cd_dma_pkg::addr_t  a;
		cd_dma_pkg::addr_t  b;
		cd_dma_pkg::count_t c;
		cd_dma_pkg::word_t  v;
		logic [23:0]        r;
		logic [2:0]         area;
		a    = pick_address();
		b    = pick_address();
		c    = restart ? 24'd6 : rnd(3) % 7;
		r    = rnd(3);
		area = r[2:0];
		r    = rnd(16);
		v    = r[15:0];
		write_reg(`CD_OFS_AREA, {13'h0, area}, 2'b01);
		set_region(`CD_OFS_MAP_SPR, `CD_OFS_UNMAP_SPR);
		set_region(`CD_OFS_MAP_PCM, `CD_OFS_UNMAP_PCM);
		set_region(`CD_OFS_MAP_Z80, `CD_OFS_UNMAP_Z80);
		set_region(`CD_OFS_MAP_FIX, `CD_OFS_UNMAP_FIX);
		write_reg(`CD_OFS_ADDR_A_HI, {8'h0, a[23:16]}, 2'b11);
		write_reg(`CD_OFS_ADDR_A_LO, a[15:0], 2'b11);
		write_reg(`CD_OFS_ADDR_B_HI, {8'h0, b[23:16]}, 2'b11);
		write_reg(`CD_OFS_ADDR_B_LO, b[15:0], 2'b11);
		write_reg(`CD_OFS_VALUE, v, 2'b11);
		write_reg(`CD_OFS_COUNT_HI, {8'h0, c[23:16]}, 2'b11);
		write_reg(`CD_OFS_COUNT_LO, c[15:0], 2'b11);
		write_reg(`CD_OFS_MICROCODE, uc, 2'b11);
		chk.begin_test(name);
		write_reg(`CD_OFS_START, 16'h0040, 2'b01);
		wait_running(1'b1, 200);
		if (restart)
			write_reg(`CD_OFS_START, 16'h0040, 2'b01);   // Must be ignored
		wait_running(1'b0, 2000);
		chk.end_test(name);
	endtask

	// ==========================================================================
	// Test sequence
	// ==========================================================================
	initial
	begin
		cd_dma_pkg::word_t uc_tab [6];
		string             name_tab [6];
		int                sel;
		uc_tab   = '{`CD_UC_COPY_WORD_A, `CD_UC_COPY_WORD_B, `CD_UC_COPY_BYTE_A,
			`CD_UC_COPY_BYTE_B, `CD_UC_FILL_A, `CD_UC_FILL_B};
		name_tab = '{"word_copy", "word_copy", "byte_copy", "byte_copy", "fill", "fill"};
		nRESET        = 1'b0;
		cpu_wr        = '0;
		cpu_wr_valid  = 1'b0;
		bus_grant     = 1'b0;
		bus_quiet     = 1'b0;
		mem_req_ready = 1'b0;
		mem_rd_valid  = 1'b0;
		mem_rd_data   = '0;
		repeat (10) @(posedge clk_sys);
		#1;
		nRESET = 1'b1;

		for (int i = 0; i < 18; i++)
		begin
			sel = rnd(3) % 6;
			run_dma(name_tab[sel], uc_tab[sel], 1'b0);
		end
		run_dma("start_while_running", `CD_UC_COPY_BYTE_A, 1'b1);

		// Unknown microcode, the checker flags any bus request in this window
		write_reg(`CD_OFS_MICROCODE, 16'h1234, 2'b11);
		chk.begin_test("unknown_microcode");
		write_reg(`CD_OFS_START, 16'h0040, 2'b01);
		for (int n = 0; n < 100; n++)
		begin
			@(posedge clk_sys);
			#1;
		end
		chk.end_test("unknown_microcode");

		chk.report_totals();
		if (chk.fail_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* src.f */
+incdir+include
src/cd_dma_pkg.sv
src/cd_dma_regs.sv
src/cd_dma_engine.sv
src/cd_upload_gate.sv
src/cd_dma_top.sv
sim/cd_dma_checker.sv
sim/tb_cd_dma.sv
